//--- Bender.yml
package:
  name: spi_flash

sources:
  - design/spi_flash_pkg.sv
  - design/spi_flash_regs.sv
  - design/spi_flash_port_mux.sv
  - design/spi_flash_engine.sv
  - design/spi_flash_top.sv
  - target: simulation
    files:
      - sim/flash_model.sv
      - sim/spi_flash_properties.sv
      - sim/spi_flash_checker.sv
      - sim/tb_spi_flash.sv

//--- design/spi_flash_engine.sv
`timescale 1ns/1ps
`default_nettype none

module spi_flash_engine (
  input  logic                     clk_i,
  input  logic                     arst_i,
  input  logic                     soft_rst_i,
  input  spi_flash_pkg::xfer_req_t req_i,
  input  logic                     start_i,
  input  logic                     miso_i,
  output logic                     idle_o,
  output logic                     done_o,
  output spi_flash_pkg::data_t     rdata_o,
  output logic                     sclk_o,
  output logic                     ss_o,
  output logic                     mosi_o
);

  import spi_flash_pkg::*;

  eng_state_t state_q;
  eng_state_t next_phase;
  div_cnt_t   div_q;
  nbits_t     bit_q;
  data_t      tx_q;
  data_t      rx_q;
  logic       level_end;
  logic       last_bit;
  logic       rise;
  logic       fall;
  logic       shifting;

  assign idle_o    = (state_q == IDLE);
  assign shifting  = (state_q == CMD) || (state_q == ADDR) || (state_q == DATA);
  assign level_end = (div_q == '0);
  assign last_bit  = (bit_q == '0);
  assign rise      = shifting & level_end & ~sclk_o;
  assign fall      = shifting & level_end & sclk_o;

  // bits leave MSB first from the top of the shift register
  assign mosi_o  = tx_q[$bits(data_t)-1];
  assign rdata_o = rx_q;

  // phase that follows the last bit of the current one
  always_comb begin
    next_phase = FINISH;
    if ((state_q == CMD) && req_i.addr_en) begin
      next_phase = ADDR;
    end else if ((state_q != DATA) && (req_i.nbits != '0)) begin
      next_phase = DATA;
    end
  end

  always_ff @(posedge clk_i or posedge arst_i) begin
    if (arst_i) begin
      state_q <= IDLE;
      div_q   <= '0;
      bit_q   <= '0;
      tx_q    <= '0;
      sclk_o  <= 1'b0;
      ss_o    <= 1'b1;
      done_o  <= 1'b0;
    end else if (soft_rst_i) begin
      state_q <= IDLE;
      div_q   <= '0;
      bit_q   <= '0;
      tx_q    <= '0;
      sclk_o  <= 1'b0;
      ss_o    <= 1'b1;
      done_o  <= 1'b0;
    end else begin
      done_o <= 1'b0;
      case (state_q)
        IDLE: begin
          if (start_i) begin
            state_q <= CMD;
            ss_o    <= 1'b0;
            // one extra clock in the first low level gives setup after SS falls
            div_q   <= div_cnt_t'(SCLK_LEVEL_CLKS);
            bit_q   <= nbits_t'($bits(cmd_t) - 1);
            tx_q    <= {req_i.command, {($bits(data_t) - $bits(cmd_t)){1'b0}}};
          end
        end
        CMD, ADDR, DATA: begin
          if (!level_end) begin
            div_q <= div_q - 1'b1;
          end else begin
            div_q  <= div_cnt_t'(SCLK_LEVEL_CLKS - 1);
            sclk_o <= ~sclk_o;
            if (fall && !last_bit) begin
              bit_q <= bit_q - 1'b1;
              tx_q  <= {tx_q[$bits(data_t)-2:0], 1'b0};
            end else if (fall) begin
              state_q <= next_phase;
              case (next_phase)
                ADDR: begin
                  bit_q <= nbits_t'($bits(flash_addr_t) - 1);
                  tx_q  <= {req_i.address, {($bits(data_t) - $bits(flash_addr_t)){1'b0}}};
                end
                DATA: begin
                  bit_q <= req_i.nbits - 1'b1;
                  tx_q  <= req_i.dir_tx ? req_i.wdata : '0;
                end
                default: begin
                  ss_o <= 1'b1;
                  tx_q <= '0;
                end
              endcase
            end
          end
        end
        FINISH: begin
          // SS has been high for one clock here
          state_q <= IDLE;
          done_o  <= 1'b1;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // MISO is sampled as SCLK rises, so read data ends up right-aligned
  always_ff @(posedge clk_i) begin
    if (idle_o && start_i && !soft_rst_i) begin
      rx_q <= '0;
    end else if (rise && (state_q == DATA) && !req_i.dir_tx) begin
      rx_q <= {rx_q[$bits(data_t)-2:0], miso_i};
    end
  end

endmodule

`default_nettype wire

//--- design/spi_flash_pkg.sv
`default_nettype none

package spi_flash_pkg;

  typedef logic [31:0] data_t;
  typedef logic [2:0]  reg_addr_t;
  typedef logic [23:0] flash_addr_t;
  typedef logic [7:0]  cmd_t;
  typedef logic [5:0]  nbits_t;

  // register word addresses
  localparam reg_addr_t REG_DATAIN  = 3'd0;
  localparam reg_addr_t REG_ADDRESS = 3'd1;
  localparam reg_addr_t REG_COMMAND = 3'd2;
  localparam reg_addr_t REG_CONTROL = 3'd3;
  localparam reg_addr_t REG_STATUS  = 3'd4;
  localparam reg_addr_t REG_DATAOUT = 3'd5;

  // COMMAND holds the opcode in its low byte
  localparam int unsigned CMD_NBITS_LSB   = 8;
  localparam int unsigned CMD_ADDR_EN_BIT = 16;
  localparam int unsigned CMD_DIR_BIT     = 17;

  localparam int unsigned CTRL_START_BIT  = 0;
  localparam int unsigned CTRL_SRST_BIT   = 1;
  localparam int unsigned STATUS_IDLE_BIT = 0;

  localparam cmd_t   CMD_READ    = 8'h03;
  localparam nbits_t CACHE_NBITS = 6'd32;

  localparam int unsigned CLKS_PER_HALF_SCLK = 2;
  // each SCLK level spans two divider steps, so one period is 4 * CLKS_PER_HALF_SCLK clocks
  localparam int unsigned SCLK_LEVEL_CLKS = 2 * CLKS_PER_HALF_SCLK;

  typedef logic [$clog2(SCLK_LEVEL_CLKS + 1)-1:0] div_cnt_t;

  typedef struct packed {
    cmd_t        command;
    logic        addr_en;
    logic        dir_tx;
    nbits_t      nbits;
    flash_addr_t address;
    data_t       wdata;
  } xfer_req_t;

  typedef enum logic [2:0] {
    IDLE,
    CMD,
    ADDR,
    DATA,
    FINISH
  } eng_state_t;

endpackage

`default_nettype wire

//--- design/spi_flash_port_mux.sv
`timescale 1ns/1ps
`default_nettype none

module spi_flash_port_mux (
  input  logic                       clk_i,
  input  logic                       arst_i,
  input  spi_flash_pkg::xfer_req_t   reg_req_i,
  input  logic                       reg_start_i,
  input  logic                       cache_valid_i,
  input  spi_flash_pkg::flash_addr_t cache_addr_i,
  input  logic                       eng_idle_i,
  input  logic                       eng_done_i,
  input  spi_flash_pkg::data_t       eng_rdata_i,
  input  logic                       soft_rst_i,
  output spi_flash_pkg::xfer_req_t   eng_req_o,
  output logic                       eng_start_o,
  output logic                       cache_ready_o,
  output spi_flash_pkg::data_t       cache_rdata_o
);

  import spi_flash_pkg::*;

  xfer_req_t cache_req;
  logic      free;
  logic      cache_go;
  logic      reg_go;
  logic      cache_own_q;

  assign cache_req.command = CMD_READ;
  assign cache_req.addr_en = 1'b1;
  assign cache_req.dir_tx  = 1'b0;
  assign cache_req.nbits   = CACHE_NBITS;
  assign cache_req.address = cache_addr_i;
  assign cache_req.wdata   = '0;

  // the engine still reports idle during the start pulse itself
  assign free = eng_idle_i & ~eng_start_o & ~soft_rst_i;

  // a cache fill beats a register start in the same cycle
  assign cache_go = free & cache_valid_i & ~cache_own_q;
  assign reg_go   = free & reg_start_i & ~cache_go;

  always_ff @(posedge clk_i or posedge arst_i) begin
    if (arst_i) begin
      eng_start_o <= 1'b0;
      cache_own_q <= 1'b0;
    end else if (soft_rst_i) begin
      eng_start_o <= 1'b0;
      cache_own_q <= 1'b0;
    end else begin
      eng_start_o <= cache_go | reg_go;
      if (cache_go) begin
        cache_own_q <= 1'b1;
      end else if (eng_done_i) begin
        cache_own_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (cache_go) begin
      eng_req_o <= cache_req;
    end else if (reg_go) begin
      eng_req_o <= reg_req_i;
    end
  end

  // only the done of a transfer the cache started is passed on
  assign cache_ready_o = cache_own_q & eng_done_i;
  assign cache_rdata_o = eng_rdata_i;

endmodule

`default_nettype wire

//--- design/spi_flash_regs.sv
`timescale 1ns/1ps
`default_nettype none

module spi_flash_regs (
  input  logic                     clk_i,
  input  logic                     arst_i,
  input  logic                     reg_valid_i,
  input  spi_flash_pkg::reg_addr_t reg_addr_i,
  input  spi_flash_pkg::data_t     reg_wdata_i,
  input  logic [3:0]               reg_wstrb_i,
  input  logic                     eng_idle_i,
  input  spi_flash_pkg::data_t     eng_rdata_i,
  output logic                     reg_ready_o,
  output logic                     reg_rvalid_o,
  output spi_flash_pkg::data_t     reg_rdata_o,
  output spi_flash_pkg::xfer_req_t req_o,
  output logic                     start_o,
  output logic                     soft_rst_o
);

  import spi_flash_pkg::*;

  logic        wr_en;
  logic        rd_en;
  logic        ctrl_wr;
  data_t       datain_q;
  flash_addr_t address_q;
  data_t       command_q;
  data_t       rdata_d;

  // the block never stalls, so every request is taken in its own cycle
  assign reg_ready_o = reg_valid_i;
  assign wr_en       = reg_valid_i & (|reg_wstrb_i);
  assign rd_en       = reg_valid_i & ~(|reg_wstrb_i);

  always_ff @(posedge clk_i or posedge arst_i) begin
    if (arst_i) begin
      datain_q  <= '0;
      address_q <= '0;
      command_q <= '0;
    end else if (wr_en) begin
      case (reg_addr_i)
        REG_DATAIN:  datain_q  <= reg_wdata_i;
        REG_ADDRESS: address_q <= reg_wdata_i[$bits(flash_addr_t)-1:0];
        REG_COMMAND: command_q <= reg_wdata_i;
        default: ;
      endcase
    end
  end

  // CONTROL is not stored, its bits only fire pulses
  assign ctrl_wr    = wr_en && (reg_addr_i == REG_CONTROL);
  assign start_o    = ctrl_wr & reg_wdata_i[CTRL_START_BIT];
  assign soft_rst_o = ctrl_wr & reg_wdata_i[CTRL_SRST_BIT];

  always_comb begin
    rdata_d = '0;
    case (reg_addr_i)
      REG_DATAIN:  rdata_d = datain_q;
      REG_ADDRESS: rdata_d = data_t'(address_q);
      REG_COMMAND: rdata_d = command_q;
      REG_STATUS:  rdata_d[STATUS_IDLE_BIT] = eng_idle_i;
      REG_DATAOUT: rdata_d = eng_rdata_i;
      default:     rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i or posedge arst_i) begin
    if (arst_i) begin
      reg_rvalid_o <= 1'b0;
    end else begin
      reg_rvalid_o <= rd_en;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      reg_rdata_o <= rdata_d;
    end
  end

  assign req_o.command  = command_q[$bits(cmd_t)-1:0];
  assign req_o.nbits    = command_q[CMD_NBITS_LSB +: $bits(nbits_t)];
  assign req_o.addr_en  = command_q[CMD_ADDR_EN_BIT];
  assign req_o.dir_tx   = command_q[CMD_DIR_BIT];
  assign req_o.address  = address_q;
  assign req_o.wdata    = datain_q;

endmodule

`default_nettype wire

//--- design/spi_flash_top.sv
`timescale 1ns/1ps
`default_nettype none

module spi_flash_top (
  input  logic                       clk_i,
  input  logic                       arst_i,
  input  logic                       reg_valid_i,
  input  spi_flash_pkg::reg_addr_t   reg_addr_i,
  input  spi_flash_pkg::data_t       reg_wdata_i,
  input  logic [3:0]                 reg_wstrb_i,
  input  logic                       cache_valid_i,
  input  spi_flash_pkg::flash_addr_t cache_addr_i,
  input  logic                       miso_i,
  output logic                       reg_ready_o,
  output logic                       reg_rvalid_o,
  output spi_flash_pkg::data_t       reg_rdata_o,
  output logic                       cache_ready_o,
  output spi_flash_pkg::data_t       cache_rdata_o,
  output logic                       sclk_o,
  output logic                       ss_o,
  output logic                       mosi_o,
  output logic                       wp_n_o,
  output logic                       hold_n_o
);

  import spi_flash_pkg::*;

  xfer_req_t reg_req;
  xfer_req_t eng_req;
  logic      reg_start;
  logic      soft_rst;
  logic      eng_start;
  logic      eng_idle;
  logic      eng_done;
  data_t     eng_rdata;

  spi_flash_regs i_regs (
    .clk_i        (clk_i),
    .arst_i       (arst_i),
    .reg_valid_i  (reg_valid_i),
    .reg_addr_i   (reg_addr_i),
    .reg_wdata_i  (reg_wdata_i),
    .reg_wstrb_i  (reg_wstrb_i),
    .eng_idle_i   (eng_idle),
    .eng_rdata_i  (eng_rdata),
    .reg_ready_o  (reg_ready_o),
    .reg_rvalid_o (reg_rvalid_o),
    .reg_rdata_o  (reg_rdata_o),
    .req_o        (reg_req),
    .start_o      (reg_start),
    .soft_rst_o   (soft_rst)
  );

  spi_flash_port_mux i_port_mux (
    .clk_i         (clk_i),
    .arst_i        (arst_i),
    .reg_req_i     (reg_req),
    .reg_start_i   (reg_start),
    .cache_valid_i (cache_valid_i),
    .cache_addr_i  (cache_addr_i),
    .eng_idle_i    (eng_idle),
    .eng_done_i    (eng_done),
    .eng_rdata_i   (eng_rdata),
    .soft_rst_i    (soft_rst),
    .eng_req_o     (eng_req),
    .eng_start_o   (eng_start),
    .cache_ready_o (cache_ready_o),
    .cache_rdata_o (cache_rdata_o)
  );

  spi_flash_engine i_engine (
    .clk_i      (clk_i),
    .arst_i     (arst_i),
    .soft_rst_i (soft_rst),
    .req_i      (eng_req),
    .start_i    (eng_start),
    .miso_i     (miso_i),
    .idle_o     (eng_idle),
    .done_o     (eng_done),
    .rdata_o    (eng_rdata),
    .sclk_o     (sclk_o),
    .ss_o       (ss_o),
    .mosi_o     (mosi_o)
  );

  // single-bit mode only, so write protect and hold stay inactive
  assign wp_n_o   = 1'b1;
  assign hold_n_o = 1'b1;

endmodule

`default_nettype wire

//--- sim.f
design/spi_flash_pkg.sv
design/spi_flash_regs.sv
design/spi_flash_port_mux.sv
design/spi_flash_engine.sv
design/spi_flash_top.sv
sim/flash_model.sv
sim/spi_flash_properties.sv
sim/spi_flash_checker.sv
sim/tb_spi_flash.sv

//--- sim/flash_model.sv
`timescale 1ns/1ps
`default_nettype none

module flash_model (
  input  logic                       sclk_i,
  input  logic                       ss_i,
  input  logic                       mosi_i,
  output logic                       miso_o,
  output spi_flash_pkg::cmd_t        last_cmd_o,
  output spi_flash_pkg::flash_addr_t last_addr_o,
  output spi_flash_pkg::data_t       last_data_o
);

  import spi_flash_pkg::*;

  int unsigned bit_cnt;
  int unsigned offset;
  cmd_t        cmd_sh;
  flash_addr_t addr_sh;
  data_t       data_sh;
  logic [7:0]  byte_q;

  // memory contents follow from the address alone
  function automatic logic [7:0] byte_at(input flash_addr_t a);
    return a[7:0] ^ a[15:8] ^ 8'h5a;
  endfunction

  initial begin
    miso_o      = 1'b0;
    bit_cnt     = 0;
    cmd_sh      = '0;
    addr_sh     = '0;
    data_sh     = '0;
    last_cmd_o  = '0;
    last_addr_o = '0;
    last_data_o = '0;
  end

  always @(negedge ss_i) begin
    bit_cnt = 0;
    data_sh = '0;
    miso_o  = 1'b0;
  end

  // every frame is taken as command, 24-bit address, then data
  always @(posedge sclk_i) begin
    if (!ss_i) begin
      if (bit_cnt < 8) begin
        cmd_sh = {cmd_sh[6:0], mosi_i};
      end else if (bit_cnt < 32) begin
        addr_sh = {addr_sh[22:0], mosi_i};
      end else begin
        data_sh = {data_sh[30:0], mosi_i};
      end
      bit_cnt = bit_cnt + 1;
    end
  end

  // read data changes after the falling edge so it is stable at the rising one
  always @(negedge sclk_i) begin
    if (!ss_i && (cmd_sh == spi_flash_pkg::CMD_READ) && (bit_cnt >= 32)) begin
      offset = bit_cnt - 32;
      byte_q = byte_at(addr_sh + flash_addr_t'(offset / 8));
      miso_o = byte_q[7 - (offset % 8)];
    end
  end

  always @(posedge ss_i) begin
    last_cmd_o  = cmd_sh;
    last_addr_o = addr_sh;
    last_data_o = data_sh;
  end

endmodule

`default_nettype wire

//--- sim/spi_flash_checker.sv
`timescale 1ns/1ps
`default_nettype none

module spi_flash_checker (
  input logic                       arst_i,
  input logic                       ss_i,
  input logic                       sclk_i,
  input logic                       mosi_i,
  input logic                       wp_n_i,
  input logic                       hold_n_i,
  input logic                       reg_rvalid_i,
  input logic                       cache_ready_i,
  input spi_flash_pkg::data_t       reg_rdata_i,
  input spi_flash_pkg::data_t       cache_rdata_i,
  input spi_flash_pkg::cmd_t        frame_cmd_i,
  input spi_flash_pkg::flash_addr_t frame_addr_i,
  input spi_flash_pkg::data_t       frame_data_i
);

  int unsigned check_count = 0;
  int unsigned error_count = 0;

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("[FAIL] %s: expected %08h, actual %08h", name, exp, act);
    end
  endtask

  task automatic note_problem(input string msg);
    error_count++;
    $display("error: %s", msg);
  endtask

  task automatic check_read(input string name, input logic [31:0] exp);
    compare(name, exp, reg_rdata_i);
  endtask

  task automatic check_cache(input string name, input logic [31:0] exp);
    compare(name, exp, cache_rdata_i);
  endtask

  task automatic check_frame(input string name, input logic [23:0] addr,
                             input logic [7:0] cmd, input logic [31:0] data);
    compare({name, " command"}, 32'(cmd), 32'(frame_cmd_i));
    compare({name, " address"}, 32'(addr), 32'(frame_addr_i));
    compare({name, " data"}, data, frame_data_i);
  endtask

  task automatic report_counts();
    $display("checks run: %0d, errors: %0d", check_count, error_count);
  endtask

  // pin levels right after the reset is released
  always @(negedge arst_i) begin
    compare("reset ss", 32'd1, 32'(ss_i));
    compare("reset sclk", 32'd0, 32'(sclk_i));
    compare("reset mosi", 32'd0, 32'(mosi_i));
    compare("reset wp_n", 32'd1, 32'(wp_n_i));
    compare("reset hold_n", 32'd1, 32'(hold_n_i));
    compare("reset reg_rvalid", 32'd0, 32'(reg_rvalid_i));
    compare("reset cache_ready", 32'd0, 32'(cache_ready_i));
  end

endmodule

`default_nettype wire

//--- sim/spi_flash_patterns.txt
// op_arg_data_expect: 01 write reg, 02 read reg, 03 wait idle, 04 cache read,
// 05 soft reset, 06 frame check (arg address, data command), ff end
02_000004_00000000_00000001
01_000001_ff123456_00000000
02_000001_00000000_00123456
01_000002_00012003_00000000
02_000002_00000000_00012003
02_000006_00000000_00000000
01_000001_00001234_00000000
01_000003_00000001_00000000
03_000000_00000000_00000000
02_000005_00000000_7c7d7e7f
01_000001_0000abcd_00000000
01_000002_00010803_00000000
01_000003_00000001_00000000
03_000000_00000000_00000000
02_000005_00000000_0000003c
01_000000_a5c31234_00000000
01_000001_00000200_00000000
01_000002_00031002_00000000
01_000003_00000001_00000000
02_000004_00000000_00000000
03_000000_00000000_00000000
06_000200_00000002_0000a5c3
04_000100_00000000_5b5a5958
01_000003_00000001_00000000
04_00f0f0_00000000_5a5b5859
06_00f0f0_00000003_00000000
01_000001_00004000_00000000
01_000002_00012003_00000000
01_000003_00000001_00000000
05_000000_00000000_00000000
02_000004_00000000_00000001
01_000003_00000001_00000000
03_000000_00000000_00000000
02_000005_00000000_1a1b1819
ff_000000_00000000_00000000

//--- sim/spi_flash_properties.sv
`timescale 1ns/1ps
`default_nettype none

module spi_flash_properties (
  input logic       clk_i,
  input logic       arst_i,
  input logic       ss_i,
  input logic       sclk_i,
  input logic       cache_ready_i,
  input logic       reg_valid_i,
  input logic       reg_ready_i,
  input logic [3:0] reg_wstrb_i,
  input logic       reg_rvalid_i
);

  logic rd_accept;

  assign rd_accept = reg_valid_i & reg_ready_i & ~(|reg_wstrb_i);

  sclk_idle_low: assert property (@(posedge clk_i) disable iff (arst_i) ss_i |-> !sclk_i)
    else $error("sclk toggled while ss was high");

  ready_one_cycle: assert property (@(posedge clk_i) disable iff (arst_i)
    cache_ready_i |=> !cache_ready_i)
    else $error("cache_ready_o stayed high for more than one cycle");

  rvalid_after_read: assert property (@(posedge clk_i) disable iff (arst_i)
    rd_accept |=> reg_rvalid_i)
    else $error("reg_rvalid_o missing after an accepted read");

  rvalid_only_after_read: assert property (@(posedge clk_i) disable iff (arst_i)
    reg_rvalid_i |-> $past(rd_accept))
    else $error("reg_rvalid_o without an accepted read");

endmodule

bind spi_flash_top spi_flash_properties i_properties (
  .clk_i         (clk_i),
  .arst_i        (arst_i),
  .ss_i          (ss_o),
  .sclk_i        (sclk_o),
  .cache_ready_i (cache_ready_o),
  .reg_valid_i   (reg_valid_i),
  .reg_ready_i   (reg_ready_o),
  .reg_wstrb_i   (reg_wstrb_i),
  .reg_rvalid_i  (reg_rvalid_o)
);

`default_nettype wire

//--- sim/tb_spi_flash.sv
`timescale 1ns/1ps
`default_nettype none

module tb_spi_flash;

  logic                       clk_i;
  logic                       arst_i;
  logic                       reg_valid_i;
  spi_flash_pkg::reg_addr_t   reg_addr_i;
  spi_flash_pkg::data_t       reg_wdata_i;
  logic [3:0]                 reg_wstrb_i;
  logic                       cache_valid_i;
  spi_flash_pkg::flash_addr_t cache_addr_i;
  logic                       reg_ready_o;
  logic                       reg_rvalid_o;
  spi_flash_pkg::data_t       reg_rdata_o;
  logic                       cache_ready_o;
  spi_flash_pkg::data_t       cache_rdata_o;
  logic                       sclk_o;
  logic                       ss_o;
  logic                       mosi_o;
  logic                       miso;
  logic                       wp_n_o;
  logic                       hold_n_o;
  spi_flash_pkg::cmd_t        frame_cmd;
  spi_flash_pkg::flash_addr_t frame_addr;
  spi_flash_pkg::data_t       frame_data;

  // op, argument, data, expected value
  logic [95:0] patterns [0:63];
  logic        timed_out;

  spi_flash_top i_spi_flash_top (.*, .miso_i(miso));

  flash_model i_flash_model (
    .sclk_i (sclk_o), .ss_i (ss_o), .mosi_i (mosi_o), .miso_o (miso),
    .last_cmd_o (frame_cmd), .last_addr_o (frame_addr), .last_data_o (frame_data)
  );

  spi_flash_checker i_checker (
    .arst_i (arst_i), .ss_i (ss_o), .sclk_i (sclk_o), .mosi_i (mosi_o),
    .wp_n_i (wp_n_o), .hold_n_i (hold_n_o), .reg_rvalid_i (reg_rvalid_o),
    .cache_ready_i (cache_ready_o),
    .reg_rdata_i (reg_rdata_o), .cache_rdata_i (cache_rdata_o),
    .frame_cmd_i (frame_cmd), .frame_addr_i (frame_addr), .frame_data_i (frame_data)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // one bus request that waits for ready, and for rvalid on a read
  task automatic reg_access(input logic write, input logic [2:0] a, input logic [31:0] d);
    int   n;
    logic accepted;
    @(posedge clk_i);
    reg_valid_i <= 1'b1;
    reg_addr_i  <= a;
    reg_wdata_i <= d;
    reg_wstrb_i <= write ? 4'hf : 4'h0;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!reg_ready_o && n < 8);
    accepted = reg_ready_o;
    @(posedge clk_i);
    reg_valid_i <= 1'b0;
    reg_wstrb_i <= 4'h0;
    if (!accepted) begin
      i_checker.note_problem("the register block never accepted the request");
      timed_out = 1'b1;
    end else if (!write) begin
      n = 0;
      do begin
        @(negedge clk_i);
        n++;
      end while (!reg_rvalid_o && n < 8);
      if (!reg_rvalid_o) begin
        i_checker.note_problem("no read response came back from the register block");
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    do begin
      reg_access(1'b0, spi_flash_pkg::REG_STATUS, '0);
      n++;
    end while (!reg_rdata_o[0] && !timed_out && n < 500);
    if (!reg_rdata_o[0] && !timed_out) begin
      i_checker.note_problem("the engine never returned to idle");
      timed_out = 1'b1;
    end
  endtask

  task automatic cache_read(input string name, input logic [23:0] a, input logic [31:0] exp);
    int n;
    @(posedge clk_i);
    cache_valid_i <= 1'b1;
    cache_addr_i  <= a;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!cache_ready_o && n < 2000);
    if (cache_ready_o) begin
      i_checker.check_cache(name, exp);
    end else begin
      i_checker.note_problem("the cache read was never answered");
      timed_out = 1'b1;
    end
    @(posedge clk_i);
    cache_valid_i <= 1'b0;
  endtask

  task automatic abort_transfer(input string name);
    int n;
    n = 0;
    while (ss_o && n < 50) begin
      @(negedge clk_i);
      n++;
    end
    if (ss_o) begin
      i_checker.note_problem("no transfer was running when the soft reset was due");
      timed_out = 1'b1;
    end else begin
      reg_access(1'b1, spi_flash_pkg::REG_CONTROL, 32'h2);
      repeat (2) @(negedge clk_i);
      i_checker.compare(name, 32'd1, 32'(ss_o));
    end
  endtask

  initial begin
    logic [7:0]  op;
    logic [23:0] arg;
    logic [31:0] data;
    logic [31:0] exp;
    string       name;
    arst_i        = 1'b1;
    reg_valid_i   = 1'b0;
    reg_addr_i    = '0;
    reg_wdata_i   = '0;
    reg_wstrb_i   = '0;
    cache_valid_i = 1'b0;
    cache_addr_i  = '0;
    timed_out     = 1'b0;
    $readmemh("sim/spi_flash_patterns.txt", patterns);
    repeat (4) @(posedge clk_i);
    arst_i <= 1'b0;
    for (int i = 0; i < 64 && !timed_out; i++) begin
      {op, arg, data, exp} = patterns[i];
      if (op === 8'hff || $isunknown(op)) begin
        break;
      end
      name = $sformatf("pattern %0d op %0h arg %0h", i, op, arg);
      case (op)
        8'h01: reg_access(1'b1, arg[2:0], data);
        8'h02: begin
          reg_access(1'b0, arg[2:0], '0);
          if (!timed_out) begin
            i_checker.check_read(name, exp);
          end
        end
        8'h03: wait_idle();
        8'h04: cache_read(name, arg, exp);
        8'h05: abort_transfer(name);
        8'h06: i_checker.check_frame(name, arg, data[7:0], exp);
        default: i_checker.note_problem($sformatf("unknown opcode in pattern %0d", i));
      endcase
    end
    repeat (4) @(posedge clk_i);
    i_checker.report_counts();
    if (timed_out || i_checker.error_count != 0) begin
      $display("=== FAIL ===");
    end else begin
      $display("=== PASS ===");
    end
    $finish;
  end

  initial begin
    #500000;
    $display("error: the simulation ran past its time limit");
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire
